//--- hdl/ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// frame and reply word width
`define FRAME_W 32

// one configuration register
`define REG_W 8

// addresses 0 to 9, reads above return zero
`define NUM_REGS 10

// marker in the top nibble of every reply
`define REPLY_TAG 4'b1001

// x^8 + x^2 + x + 1, msb first, init 0
`define CRC_POLY 8'h07

// control register reset values
`define REG0_RST 8'h00
`define REG1_RST 8'h02   // pixel_calib_en set

`endif

//--- hdl/ctrl_pkg.sv
`include "ctrl_macros.svh"

package ctrl_pkg;

    // opcode field, frame bits 27:24
    typedef enum logic [3:0] {
        CMD_DUMMY        = 4'd1,
        CMD_REG_SET      = 4'd2,
        CMD_REG_GET      = 4'd3,
        CMD_RESET_DLY    = 4'd4,
        CMD_RESET_PIXEL  = 4'd5,
        CMD_RESET_ANALOG = 4'd6
    } cmd_e;

    // state codes as reported in replies
    typedef enum logic [3:0] {
        ST_IDLE         = 4'd0,
        ST_REG_SET      = 4'd2,
        ST_REG_GET      = 4'd3,
        ST_RESET_DLY    = 4'd4,
        ST_RESET_PIXEL  = 4'd5,
        ST_RESET_ANALOG = 4'd6
    } state_e;

    // crc-8 over the upper 24 bits of a frame, msb first
    function automatic logic [7:0] crc8(input logic [23:0] data);
        logic [7:0] crc;
        logic       fb;
        crc = 8'h00;
        for (int i = 23; i >= 0; i--)
        begin
            fb  = crc[7] ^ data[i];
            crc = {crc[6:0], 1'b0};
            if (fb)
            begin
                crc = crc ^ `CRC_POLY;
            end
        end
        return crc;
    endfunction

endpackage

//--- hdl/frame_decoder.sv
`include "ctrl_macros.svh"

module frame_decoder (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                frame_valid,
    input  logic [`FRAME_W-1:0] frame_data,
    output logic                cmd_valid,
    output ctrl_pkg::cmd_e      cmd_op,
    output logic [`REG_W-1:0]   cmd_addr,
    output logic [`REG_W-1:0]   cmd_wdata,
    output logic                crc_ok
);

    logic [7:0] crc_calc;

    // received crc sits in the low byte
    assign crc_calc = ctrl_pkg::crc8(frame_data[`FRAME_W-1:8]);

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cmd_valid <= 1'b0;
        end
        else
        begin
            cmd_valid <= frame_valid;   // one cycle strobe
        end
    end

    // field registers, only meaningful with cmd_valid
    always_ff @(posedge CLK)
    begin
        if (frame_valid)
        begin
            // opcode is not checked here
            cmd_op    <= ctrl_pkg::cmd_e'(frame_data[27:24]);
            cmd_addr  <= frame_data[23:16];
            cmd_wdata <= frame_data[15:8];
            crc_ok    <= (frame_data[7:0] == crc_calc);
        end
    end

endmodule

//--- hdl/config_regfile.sv
`include "ctrl_macros.svh"

module config_regfile (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              wr_en,
    input  logic [`REG_W-1:0] wr_addr,
    input  logic [`REG_W-1:0] wr_data,
    input  logic [3:0]        rd_addr,
    output logic [`REG_W-1:0] rd_data,
    input  logic [14:0]       switch_dly,
    input  logic [7:0]        switch_pixel,
    output logic              cmfb_bit,
    output logic              analog_hold,
    output logic              amp_direct_out,
    output logic              bus_direct_out,
    output logic              part_work,
    output logic              CMFB_en,
    output logic              bias_direct_in,
    output logic              supply_direct_in,
    output logic              TDC_test_in,
    output logic              array_probe_select,
    output logic              pixel_calib_en
);

    logic [`REG_W-1:0] shadow0, shadow1;
    logic [`REG_W-1:0] live0, live1;
    logic [`REG_W-1:0] mirror7, mirror8, mirror9;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shadow0 <= `REG0_RST;
            shadow1 <= `REG1_RST;
            live0   <= `REG0_RST;
            live1   <= `REG1_RST;
            mirror7 <= '0;
            mirror8 <= '0;
            mirror9 <= '0;
        end
        else
        begin
            // only 0 and 1 are writable
            if (wr_en && wr_addr == 8'd0)
            begin
                shadow0 <= wr_data;
            end
            if (wr_en && wr_addr == 8'd1)
            begin
                shadow1 <= wr_data;
            end
            live0   <= shadow0;   // pins see writes one cycle later
            live1   <= shadow1;
            mirror7 <= switch_dly[7:0];
            mirror8 <= {1'b0, switch_dly[14:8]};
            mirror9 <= switch_pixel;
        end
    end

    always_comb
    begin
        case (rd_addr)
            4'd0:    rd_data = live0;
            4'd1:    rd_data = live1;
            4'd7:    rd_data = mirror7;
            4'd8:    rd_data = mirror8;
            4'd9:    rd_data = mirror9;
            default: rd_data = '0;   // reserved or beyond the map
        endcase
    end

    assign amp_direct_out     = live0[0];
    assign bus_direct_out     = live0[1];
    assign part_work          = live0[2];
    assign CMFB_en            = live0[3];
    assign bias_direct_in     = live0[4];
    assign supply_direct_in   = live0[6];
    assign TDC_test_in        = live0[7];
    assign array_probe_select = live1[0];
    assign pixel_calib_en     = live1[1];

    assign cmfb_bit    = live0[3];
    assign analog_hold = live0[5];   // keeps analog reset asserted

endmodule

//--- hdl/cmd_sequencer.sv
`include "ctrl_macros.svh"

module cmd_sequencer (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                cmd_valid,
    input  ctrl_pkg::cmd_e      cmd_op,
    input  logic [`REG_W-1:0]   cmd_addr,
    input  logic [`REG_W-1:0]   cmd_wdata,
    input  logic                crc_ok,
    output logic                wr_en,
    output logic [`REG_W-1:0]   wr_addr,
    output logic [`REG_W-1:0]   wr_data,
    output logic [3:0]          rd_addr,
    input  logic [`REG_W-1:0]   rd_data,
    input  logic                cmfb_bit,
    input  logic                analog_hold,
    output logic                rst_dly_calib,
    output logic                rst_pixel_calib,
    output logic                rst_analog,
    output logic [`FRAME_W-1:0] reply_data
);

    ctrl_pkg::state_e  state_q, state_d;
    logic [3:0]        cnt;            // frame count, or read index in reg get
    logic [`REG_W-1:0] addr_q;
    logic [3:0]        last_op;
    logic              last_crc_ok;
    logic              good_frame;
    logic              set_write;
    logic              pulse_low;
    logic              rst_analog_q;
    logic [3:0]        op_now;
    logic              crc_now;
    logic              load_reply;
    logic [23:0]       payload;

    assign good_frame = cmd_valid && crc_ok;
    assign set_write  = (state_q == ctrl_pkg::ST_REG_SET) && good_frame && (cnt == 4'd1);
    // low from the first frame of a reset command until the second
    assign pulse_low  = (cnt == 4'd0 && cmd_valid) || (cnt == 4'd1 && !cmd_valid);

    // status shows the frame being decoded this cycle
    assign op_now  = cmd_valid ? cmd_op : last_op;
    assign crc_now = cmd_valid ? crc_ok : last_crc_ok;

    // addresses above 15 must not alias onto the map
    assign rd_addr = (state_q == ctrl_pkg::ST_REG_GET) ? cnt :
                     (addr_q[7:4] != 4'd0) ? 4'hF : addr_q[3:0];

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ctrl_pkg::ST_IDLE:
            begin
                if (good_frame)
                begin
                    case (cmd_op)
                        ctrl_pkg::CMD_REG_SET:      state_d = ctrl_pkg::ST_REG_SET;
                        ctrl_pkg::CMD_REG_GET:      state_d = ctrl_pkg::ST_REG_GET;
                        ctrl_pkg::CMD_RESET_DLY:    state_d = ctrl_pkg::ST_RESET_DLY;
                        ctrl_pkg::CMD_RESET_PIXEL:  state_d = ctrl_pkg::ST_RESET_PIXEL;
                        ctrl_pkg::CMD_RESET_ANALOG: state_d = ctrl_pkg::ST_RESET_ANALOG;
                        default:                    state_d = ctrl_pkg::ST_IDLE;
                    endcase
                end
            end
            ctrl_pkg::ST_REG_SET:
            begin
                if (set_write)
                begin
                    state_d = ctrl_pkg::ST_IDLE;
                end
            end
            ctrl_pkg::ST_REG_GET:
            begin
                if (good_frame && cmd_op != ctrl_pkg::CMD_REG_GET
                    && cmd_op != ctrl_pkg::CMD_DUMMY)
                begin
                    state_d = ctrl_pkg::ST_IDLE;
                end
            end
            default:   // the three reset commands
            begin
                if (cmd_valid && cnt == 4'd1)
                begin
                    state_d = ctrl_pkg::ST_IDLE;
                end
            end
        endcase
    end

    always_comb
    begin
        load_reply = 1'b1;
        payload    = {`REPLY_TAG, state_q, cmfb_bit, 10'b0, op_now, crc_now};
        case (state_q)
            ctrl_pkg::ST_REG_SET:
            begin
                load_reply = set_write;
                payload    = {`REPLY_TAG, state_q, addr_q, rd_data};  // old value
            end
            ctrl_pkg::ST_REG_GET:
            begin
                load_reply = cmd_valid;   // crc not required here
                payload    = {`REPLY_TAG, state_q, 4'b0, cnt, rd_data};
            end
            default:
            begin
                load_reply = 1'b1;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q         <= ctrl_pkg::ST_IDLE;
            cnt             <= 4'd0;
            last_op         <= 4'd0;
            last_crc_ok     <= 1'b0;
            wr_en           <= 1'b0;
            rst_dly_calib   <= 1'b0;
            rst_pixel_calib <= 1'b0;
            rst_analog_q    <= 1'b0;
            reply_data      <= '0;
        end
        else
        begin
            state_q <= state_d;
            wr_en   <= set_write;
            if (cmd_valid)
            begin
                last_op     <= cmd_op;
                last_crc_ok <= crc_ok;
            end
            if (state_q == ctrl_pkg::ST_IDLE)
            begin
                cnt <= 4'd0;   // fresh count for every command
            end
            else if (state_q == ctrl_pkg::ST_REG_GET)
            begin
                if (cmd_valid)
                begin
                    cnt <= (cnt == 4'(`NUM_REGS - 1)) ? 4'd0 : cnt + 4'd1;
                end
            end
            else if (state_q == ctrl_pkg::ST_REG_SET ? good_frame : cmd_valid)
            begin
                cnt <= cnt + 4'd1;
            end
            rst_dly_calib   <= !(state_q == ctrl_pkg::ST_RESET_DLY && pulse_low);
            rst_pixel_calib <= !(state_q == ctrl_pkg::ST_RESET_PIXEL && pulse_low);
            rst_analog_q    <= !(state_q == ctrl_pkg::ST_RESET_ANALOG && pulse_low);
            if (load_reply)
            begin
                reply_data <= {payload, ctrl_pkg::crc8(payload)};
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state_q == ctrl_pkg::ST_REG_SET && good_frame && cnt == 4'd0)
        begin
            addr_q <= cmd_addr;   // first frame carries the address
        end
        if (set_write)
        begin
            wr_addr <= addr_q;
            wr_data <= cmd_wdata;
        end
    end

    assign rst_analog = rst_analog_q && !analog_hold;

endmodule

//--- hdl/ctrl_top.sv
`include "ctrl_macros.svh"

module ctrl_top (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                frame_valid,
    input  logic [`FRAME_W-1:0] frame_data,
    input  logic [14:0]         switch_dly,
    input  logic [7:0]          switch_pixel,
    output logic [`FRAME_W-1:0] reply_data,
    output logic                amp_direct_out,
    output logic                bus_direct_out,
    output logic                part_work,
    output logic                CMFB_en,
    output logic                bias_direct_in,
    output logic                supply_direct_in,
    output logic                TDC_test_in,
    output logic                array_probe_select,
    output logic                pixel_calib_en,
    output logic                rst_dly_calib,
    output logic                rst_pixel_calib,
    output logic                rst_analog
);

    logic              cmd_valid;
    ctrl_pkg::cmd_e    cmd_op;
    logic [`REG_W-1:0] cmd_addr, cmd_wdata;
    logic              crc_ok;
    logic              wr_en;
    logic [`REG_W-1:0] wr_addr, wr_data;
    logic [3:0]        rd_addr;
    logic [`REG_W-1:0] rd_data;
    logic              cmfb_bit, analog_hold;

    // frame fields, one cycle after the strobe
    frame_decoder u_decoder (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .frame_data  (frame_data),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .crc_ok      (crc_ok)
    );

    config_regfile u_regfile (
        .CLK                (CLK),
        .rst_n              (rst_n),
        .wr_en              (wr_en),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data),
        .rd_addr            (rd_addr),
        .rd_data            (rd_data),
        .switch_dly         (switch_dly),
        .switch_pixel       (switch_pixel),
        .cmfb_bit           (cmfb_bit),
        .analog_hold        (analog_hold),
        .amp_direct_out     (amp_direct_out),
        .bus_direct_out     (bus_direct_out),
        .part_work          (part_work),
        .CMFB_en            (CMFB_en),
        .bias_direct_in     (bias_direct_in),
        .supply_direct_in   (supply_direct_in),
        .TDC_test_in        (TDC_test_in),
        .array_probe_select (array_probe_select),
        .pixel_calib_en     (pixel_calib_en)
    );

    cmd_sequencer u_sequencer (
        .CLK             (CLK),
        .rst_n           (rst_n),
        .cmd_valid       (cmd_valid),
        .cmd_op          (cmd_op),
        .cmd_addr        (cmd_addr),
        .cmd_wdata       (cmd_wdata),
        .crc_ok          (crc_ok),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .cmfb_bit        (cmfb_bit),
        .analog_hold     (analog_hold),
        .rst_dly_calib   (rst_dly_calib),
        .rst_pixel_calib (rst_pixel_calib),
        .rst_analog      (rst_analog),
        .reply_data      (reply_data)
    );

endmodule

//--- sim/ctrl_top_tb.sv
module ctrl_top_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIELDS    = 7;    // kind, frame, sw_dly, sw_pixel, reply, pins, resets
    localparam int MAX_STEPS = 64;

    logic        CLK;
    logic        rst_n;
    logic        frame_valid;
    logic [31:0] frame_data;
    logic [14:0] switch_dly;
    logic [7:0]  switch_pixel;
    logic [31:0] reply_data;
    logic        amp_direct_out, bus_direct_out, part_work, CMFB_en, bias_direct_in;
    logic        supply_direct_in, TDC_test_in, array_probe_select, pixel_calib_en;
    logic        rst_dly_calib, rst_pixel_calib, rst_analog;
    logic [8:0]  pins;
    logic [2:0]  resets;

    logic [31:0] golden [0:FIELDS*MAX_STEPS-1];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          num_steps;
    int          cycles = 0;
    int          limit = 100000;   // replaced once the step count is known

    ctrl_top ctrl_top_i (
        .CLK                (CLK),
        .rst_n              (rst_n),
        .frame_valid        (frame_valid),
        .frame_data         (frame_data),
        .switch_dly         (switch_dly),
        .switch_pixel       (switch_pixel),
        .reply_data         (reply_data),
        .amp_direct_out     (amp_direct_out),
        .bus_direct_out     (bus_direct_out),
        .part_work          (part_work),
        .CMFB_en            (CMFB_en),
        .bias_direct_in     (bias_direct_in),
        .supply_direct_in   (supply_direct_in),
        .TDC_test_in        (TDC_test_in),
        .array_probe_select (array_probe_select),
        .pixel_calib_en     (pixel_calib_en),
        .rst_dly_calib      (rst_dly_calib),
        .rst_pixel_calib    (rst_pixel_calib),
        .rst_analog         (rst_analog)
    );

    // amp_direct_out in bit 0 up to pixel_calib_en in bit 8
    assign pins   = {pixel_calib_en, array_probe_select, TDC_test_in, supply_direct_in,
                     bias_direct_in, CMFB_en, part_work, bus_direct_out, amp_direct_out};
    assign resets = {rst_dly_calib, rst_pixel_calib, rst_analog};

    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
        begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // 5 to 8 idle cycles before a frame
    task automatic pick_gap(output int gap);
        gap = 5;
        for (int b = 0; b < 2; b++)
        begin
            gap = gap + (int'(lfsr[0]) << b);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_outputs(input logic [31:0] exp_reply, input logic [8:0] exp_pins,
                                 input logic [2:0] exp_rst);
        checks++;
        assert (reply_data === exp_reply)
        else
        begin
            errors++;
            $display("[FAIL] %0t reply_data: expected %h, got %h", $time, exp_reply, reply_data);
        end
        assert (pins === exp_pins)
        else
        begin
            errors++;
            $display("[FAIL] %0t pins: expected %h, got %h", $time, exp_pins, pins);
        end
        assert (resets === exp_rst)
        else
        begin
            errors++;
            $display("[FAIL] %0t resets: expected %b, got %b", $time, exp_rst, resets);
        end
    endtask

    task automatic run_step(input int s);
        int base;
        int gap;
        base = s * FIELDS;
        if (golden[base] == 32'h0)
        begin
            // state right after reset without a frame
            @(posedge CLK);
            switch_dly   <= golden[base+2][14:0];
            switch_pixel <= golden[base+3][7:0];
            repeat (4) @(posedge CLK);
        end
        else
        begin
            pick_gap(gap);
            repeat (gap - 4) @(posedge CLK);   // the check wait counts toward the gap
            frame_valid  <= 1'b1;
            frame_data   <= golden[base+1];
            switch_dly   <= golden[base+2][14:0];
            switch_pixel <= golden[base+3][7:0];
            @(posedge CLK);
            frame_valid  <= 1'b0;
            repeat (4) @(posedge CLK);
        end
        @(negedge CLK);
        check_outputs(golden[base+4], golden[base+5][8:0], golden[base+6][2:0]);
    endtask

    initial
    begin
        CLK          = 1'b0;
        rst_n        = 1'b0;
        frame_valid  = 1'b0;
        frame_data   = '0;
        switch_dly   = '0;
        switch_pixel = '0;
        errors       = 0;
        checks       = 0;
        lfsr         = 32'd90736;
        $readmemh("sim/ctrl_golden.txt", golden);
        num_steps = 0;
        while (num_steps < MAX_STEPS
               && (golden[num_steps*FIELDS] === 32'h0 || golden[num_steps*FIELDS] === 32'h1))
        begin
            num_steps++;
        end
        limit = num_steps * 8 + 100;
        repeat (16) @(posedge CLK);
        rst_n <= 1'b1;
        for (int s = 0; s < num_steps; s++)
        begin
            run_step(s);
        end
        if (num_steps == 0)
        begin
            errors++;
            $display("no steps could be read from sim/ctrl_golden.txt");
        end
        $display("steps: %0d, checks: %0d, errors: %0d", num_steps, checks, errors);
        if (errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/ctrl_golden.txt
// kind frame sw_dly sw_pixel reply pins resets, kind 0 = after reset, 1 = frame, ff ends
// pins bit 0 amp_direct_out up to bit 8 pixel_calib_en, resets {dly, pixel, analog}
0 00000000 1234 5a 900000a9 100 7
1 040000ab 1234 5a 9400093d 100 7
1 0100006b 1234 5a 9400030b 100 3
1 0100006b 1234 5a 900003a0 100 7
1 050000c0 1234 5a 95000b58 100 7
1 0100006b 1234 5a 95000360 100 5
1 0100006b 1234 5a 900003a0 100 7
1 0600007d 1234 5a 96000df7 100 7
1 0100006b 1234 5a 960003dd 100 6
1 0100006b 1234 5a 900003a0 100 7
1 020000d6 1234 5a 900005b2 100 7
1 020000d6 1234 5a 900005b2 100 7
1 02002b07 1234 5a 90800504 10b 6
1 030000bd 1234 5a 9080070a 10b 6
1 0100006b 1234 5a 93002bc5 10b 6
1 0100006b 1234 5a 9301020f 10b 6
1 0100006b 1234 5a 9302003e 10b 6
1 0100006b 1234 5a 9303002b 10b 6
1 0100006b 1234 5a 93040040 10b 6
1 0100006b 1234 5a 93050055 10b 6
1 0100006b 1234 5a 9306006a 10b 6
1 0100006b 1234 5a 930734f3 10b 6
1 0100006b 1234 5a 930812c2 10b 6
1 0100006b 1234 5a 93095a28 10b 6
1 0100006b 1234 5a 93002bc5 10b 6
1 020000d6 1234 5a 90800504 10b 6
1 0100006c 1234 5a 90800211 10b 6
1 08000051 1234 5a 90801168 10b 6
ff 0 0 0 0 0 0

//--- flist.f
+incdir+hdl
hdl/ctrl_pkg.sv
hdl/frame_decoder.sv
hdl/config_regfile.sv
hdl/cmd_sequencer.sv
hdl/ctrl_top.sv
sim/ctrl_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module ctrl_top_tb -o ctrl_sim

out=$(./obj_dir/ctrl_sim)
echo "$out"

# fails the script unless the pass line is present
echo "$out" | grep -q "^TESTS PASSED$"
